// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DCACHE_INDEX_W    6     // 64 sets
`define DCACHE_WORD_OFF_W 4     // 16 words per line
`define DCACHE_ADDR_W     32
`define DCACHE_WAYS       2

`endif

// File: hw/dcache_addr_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_addr_pkg;

    localparam int INDEX_W    = `DCACHE_INDEX_W;
    localparam int WORD_OFF_W = `DCACHE_WORD_OFF_W;
    localparam int BYTE_OFF_W = WORD_OFF_W + 2;
    localparam int TAG_W      = `DCACHE_ADDR_W - INDEX_W - BYTE_OFF_W;
    localparam int NUM_SETS   = 1 << INDEX_W;
    localparam int LINE_BYTES = 1 << BYTE_OFF_W;
    localparam int LINE_BITS  = LINE_BYTES * 8;

    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        word_off_t  word;
        logic [1:0] byte_off;
    } addr_fields_t;

    // same request word, seen raw or split into lookup fields
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: hw/dcache_access_pkg.sv
`default_nettype none

package dcache_access_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef logic [6:0] exc_code_t;

    localparam exc_code_t EXC_NONE = 7'h00;
    localparam exc_code_t EXC_ALE  = 7'h09;   // address alignment error

endpackage

`default_nettype wire

// File: hw/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram
    import dcache_addr_pkg::*;
(
    input  wire logic       clk,
    input  wire index_t     i_raddr,
    input  wire index_t     i_waddr,
    input  wire line_t      i_wdata,
    input  wire line_strb_t i_we,
    output line_t           o_rdata
);

    line_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_we[b]) begin
                mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
        end
        o_rdata <= mem[i_raddr];    // read-before-write on a collision
    end

endmodule

`default_nettype wire

// File: hw/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tag_store
    import dcache_addr_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire index_t                  i_rd_index,
    input  wire cache_addr_u             i_req_addr,
    input  wire logic [`DCACHE_WAYS-1:0] i_tag_we,
    input  wire logic                    i_dirty_set,
    input  wire logic                    i_dirty_clr,
    input  wire logic                    i_lru_we,
    input  wire logic                    i_lru_way,   // way being touched
    output logic [`DCACHE_WAYS-1:0]      o_hit,
    output logic                         o_victim_way,
    output tag_t                         o_victim_tag,
    output logic                         o_victim_dirty
);

    tag_t                    tag_mem [`DCACHE_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0]     valid [`DCACHE_WAYS];
    logic [NUM_SETS-1:0]     dirty [`DCACHE_WAYS];
    logic [NUM_SETS-1:0]     lru;       // way to replace next
    tag_t                    rd_tag [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] rd_valid;
    index_t                  idx;

    assign idx = i_req_addr.f.index;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (i_tag_we[w]) begin
                tag_mem[w][idx] <= i_req_addr.f.tag;
            end
            rd_tag[w] <= tag_mem[w][i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            rd_valid <= '0;
            lru      <= '0;
        end else begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (i_tag_we[w]) valid[w][idx] <= 1'b1;
                rd_valid[w] <= valid[w][i_rd_index];
            end
            if (i_dirty_set) begin
                dirty[i_lru_way][idx] <= 1'b1;
            end else if (i_dirty_clr) begin
                dirty[i_lru_way][idx] <= 1'b0;
            end
            if (i_lru_we) lru[idx] <= ~i_lru_way;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            o_hit[w] = rd_valid[w] && (rd_tag[w] == i_req_addr.f.tag);
        end
    end

    // an empty way is filled before anything is evicted
    assign o_victim_way   = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : lru[idx]);
    assign o_victim_tag   = rd_tag[o_victim_way];
    assign o_victim_dirty = rd_valid[o_victim_way] && dirty[o_victim_way][idx];

    // a line is only refilled after a miss, so one tag never sits in both ways
    a_one_hit : assert property (@(posedge clk) disable iff (!rstn) !(&o_hit));

endmodule

`default_nettype wire

// File: hw/load_store_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_align
    import dcache_addr_pkg::*;
    import dcache_access_pkg::*;
(
    input  wire cache_addr_u i_req_addr,
    input  wire logic [1:0]  i_size,
    input  wire logic        i_signed,
    input  wire logic [31:0] i_wdata,    // lane aligned within the word
    input  wire logic [3:0]  i_wstrb,    // zero for loads
    input  wire line_t       i_line,
    input  wire logic        i_fill_sel, // i_line is the refill line
    output line_t            o_wline,
    output line_strb_t       o_wstrb_line,
    output logic [31:0]      o_rdata,
    output logic             o_misaligned
);

    line_t       wdata_line;
    line_t       bit_mask;
    line_strb_t  strb_line;
    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  rd_byte;

    // move the store word into its slot in the line
    assign wdata_line = {{(LINE_BITS-32){1'b0}}, i_wdata} << {i_req_addr.f.word, 5'b00000};
    assign strb_line  = {{(LINE_BYTES-4){1'b0}}, i_wstrb} << {i_req_addr.f.word, 2'b00};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            bit_mask[b*8 +: 8] = {8{strb_line[b]}};
        end
    end

    assign o_wline      = (i_line & ~bit_mask) | (wdata_line & bit_mask);
    assign o_wstrb_line = i_fill_sel ? '1 : strb_line;   // refill writes the whole line

    // load side
    assign word    = i_line[{i_req_addr.f.word, 5'b00000} +: 32];
    assign half    = i_req_addr.f.byte_off[1] ? word[31:16] : word[15:0];
    assign rd_byte = word[{i_req_addr.f.byte_off, 3'b000} +: 8];

    always_comb begin
        case (acc_size_e'(i_size))
            SIZE_BYTE: o_rdata = {{24{i_signed & rd_byte[7]}}, rd_byte};
            SIZE_HALF: o_rdata = {{16{i_signed & half[15]}}, half};
            default:   o_rdata = word;
        endcase
    end

    assign o_misaligned = ((i_size == SIZE_HALF) && i_req_addr.f.byte_off[0])
                       || ((i_size == SIZE_WORD) && (i_req_addr.f.byte_off != 2'b00));

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_addr_pkg::*;
    import dcache_access_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rstn,
    // pipeline
    input  wire logic                      i_valid,
    input  wire logic [`DCACHE_ADDR_W-1:0] i_addr,
    input  wire logic                      i_op,
    input  wire logic [1:0]                i_size,
    input  wire logic [31:0]               i_wdata,
    input  wire logic [3:0]                i_wstrb,
    input  wire logic                      i_signed,
    output logic                           o_done,
    output exc_code_t                      o_exc,
    output logic [`DCACHE_ADDR_W-1:0]      o_badv,
    // memory
    output logic                           o_mem_rvalid,
    input  wire logic                      i_mem_rready,
    output logic [`DCACHE_ADDR_W-1:0]      o_mem_raddr,
    output logic                           o_mem_wvalid,
    input  wire logic                      i_mem_wready,
    output logic [`DCACHE_ADDR_W-1:0]      o_mem_waddr,
    output line_t                          o_mem_wdata,
    // tag store, line RAMs, aligner
    input  wire logic [`DCACHE_WAYS-1:0]   i_hit,
    input  wire logic                      i_victim_way,
    input  wire tag_t                      i_victim_tag,
    input  wire logic                      i_victim_dirty,
    input  wire logic                      i_misaligned,
    input  wire line_t                     i_rd_line0,
    input  wire line_t                     i_rd_line1,
    output cache_addr_u                    o_req_addr,
    output logic                           o_req_op,
    output logic [1:0]                     o_req_size,
    output logic                           o_req_signed,
    output logic [31:0]                    o_req_wdata,
    output logic [3:0]                     o_req_wstrb,
    output index_t                         o_rd_index,
    output logic [`DCACHE_WAYS-1:0]        o_ram_we,
    output logic                           o_fill_sel,
    output logic [`DCACHE_WAYS-1:0]        o_tag_we,
    output logic                           o_dirty_set,
    output logic                           o_dirty_clr,
    output logic                           o_lru_we,
    output logic                           o_lru_way,
    output logic                           o_sel_way
);

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_MISS, S_REFILL, S_WAIT_WRITE} state_e;
    typedef enum logic [1:0] {WB_INIT, WB_WRITE, WB_FINISH} wb_state_e;

    state_e                    state, state_n;
    wb_state_e                 wb_state, wb_state_n;
    cache_addr_u               in_addr;
    logic                      capture;
    logic                      chain;       // done, next request may enter lookup
    logic                      miss_start;
    logic                      hit_way;
    logic                      victim_q;
    line_t                     wbuf;
    logic [`DCACHE_ADDR_W-1:0] wb_addr;

    assign in_addr.raw = i_addr;
    assign hit_way     = i_hit[1];

    always_comb begin
        state_n      = state;
        o_done       = 1'b0;
        o_exc        = EXC_NONE;
        chain        = 1'b0;
        capture      = 1'b0;
        miss_start   = 1'b0;
        o_mem_rvalid = 1'b0;
        o_ram_we     = '0;
        o_fill_sel   = 1'b0;
        o_tag_we     = '0;
        o_dirty_set  = 1'b0;
        o_dirty_clr  = 1'b0;
        o_lru_we     = 1'b0;
        o_lru_way    = victim_q;
        o_sel_way    = victim_q;
        case (state)
            S_IDLE: begin
                capture = i_valid;
                if (i_valid) state_n = S_LOOKUP;
            end
            S_LOOKUP: begin
                o_sel_way = hit_way;
                o_lru_way = hit_way;
                if (i_misaligned) begin
                    o_done = 1'b1;
                    o_exc  = EXC_ALE;
                    chain  = 1'b1;
                end else if (|i_hit) begin
                    o_done   = 1'b1;
                    o_lru_we = 1'b1;
                    if (o_req_op == OP_STORE) begin
                        o_ram_we[hit_way] = 1'b1;
                        o_dirty_set       = 1'b1;
                        state_n           = S_IDLE;   // bubble before the next read
                    end else begin
                        chain = 1'b1;
                    end
                end else begin
                    miss_start = 1'b1;
                    state_n    = S_MISS;
                end
            end
            S_MISS: begin
                o_mem_rvalid = 1'b1;
                o_fill_sel   = 1'b1;
                if (i_mem_rready) begin
                    o_ram_we[victim_q] = 1'b1;
                    o_tag_we[victim_q] = 1'b1;
                    o_lru_we           = 1'b1;
                    o_dirty_set        = (o_req_op == OP_STORE);
                    o_dirty_clr        = (o_req_op != OP_STORE);
                    state_n            = S_REFILL;
                end
            end
            S_REFILL: state_n = S_WAIT_WRITE;   // new line reads back from the RAM
            S_WAIT_WRITE: begin
                if (wb_state == WB_FINISH) begin
                    o_done = 1'b1;
                    chain  = 1'b1;
                end
            end
            default: state_n = S_IDLE;
        endcase
        if (chain) begin
            capture = i_valid;
            state_n = i_valid ? S_LOOKUP : S_IDLE;
        end
    end

    // write-back of the victim line, alongside the refill
    always_comb begin
        wb_state_n = wb_state;
        case (wb_state)
            WB_INIT:   if (miss_start) wb_state_n = i_victim_dirty ? WB_WRITE : WB_FINISH;
            WB_WRITE:  if (i_mem_wready) wb_state_n = WB_FINISH;
            WB_FINISH: if (o_done) wb_state_n = WB_INIT;
            default:   wb_state_n = WB_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= S_IDLE;
            wb_state <= WB_INIT;
        end else begin
            state    <= state_n;
            wb_state <= wb_state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_req_addr   <= in_addr;
            o_req_op     <= i_op;
            o_req_size   <= i_size;
            o_req_signed <= i_signed;
            o_req_wdata  <= i_wdata;
            o_req_wstrb  <= (i_op == OP_STORE) ? i_wstrb : 4'b0000;
        end
        if (miss_start) begin
            victim_q <= i_victim_way;
            wbuf     <= i_victim_way ? i_rd_line1 : i_rd_line0;
            wb_addr  <= {i_victim_tag, o_req_addr.f.index, {BYTE_OFF_W{1'b0}}};
        end
    end

    assign o_rd_index   = capture ? in_addr.f.index : o_req_addr.f.index;
    assign o_badv       = (o_exc != EXC_NONE) ? o_req_addr.raw : '0;
    assign o_mem_raddr  = {o_req_addr.f.tag, o_req_addr.f.index, {BYTE_OFF_W{1'b0}}};
    assign o_mem_wvalid = (wb_state == WB_WRITE);
    assign o_mem_waddr  = wb_addr;
    assign o_mem_wdata  = wbuf;

    a_rvalid_hold : assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));
    a_wvalid_hold : assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wvalid && !i_mem_wready |=> o_mem_wvalid && $stable(o_mem_waddr));
    a_done_after_wb : assert property (@(posedge clk) disable iff (!rstn)
        !(o_done && wb_state == WB_WRITE));

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top
    import dcache_addr_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rstn,
    // pipeline side
    input  wire logic                      i_valid,
    input  wire logic [`DCACHE_ADDR_W-1:0] i_addr,
    input  wire logic                      i_op,      // 0 load, 1 store
    input  wire logic [1:0]                i_size,
    input  wire logic [31:0]               i_wdata,
    input  wire logic [3:0]                i_wstrb,
    input  wire logic                      i_signed,
    output logic                           o_done,
    output logic [31:0]                    o_rdata,
    output logic [6:0]                     o_exc,
    output logic [`DCACHE_ADDR_W-1:0]      o_badv,
    // memory side, one line per transfer
    output logic                           o_mem_rvalid,
    input  wire logic                      i_mem_rready,
    output logic [`DCACHE_ADDR_W-1:0]      o_mem_raddr,
    input  wire line_t                     i_mem_rdata,
    output logic                           o_mem_wvalid,
    input  wire logic                      i_mem_wready,
    output logic [`DCACHE_ADDR_W-1:0]      o_mem_waddr,
    output line_t                          o_mem_wdata
);

    cache_addr_u             req_addr;
    logic                    req_op;
    logic [1:0]              req_size;
    logic                    req_signed;
    logic [31:0]             req_wdata;
    logic [3:0]              req_wstrb;
    index_t                  rd_index;
    logic [`DCACHE_WAYS-1:0] hit, ram_we, tag_we;
    logic                    victim_way, victim_dirty, misaligned;
    tag_t                    victim_tag;
    logic                    fill_sel, dirty_set, dirty_clr, lru_we, lru_way, sel_way;
    line_t                   rd_line0, rd_line1, sel_line, wline;
    line_strb_t              wstrb_line;

    // refill data comes straight off the memory port
    assign sel_line = fill_sel ? i_mem_rdata : (sel_way ? rd_line1 : rd_line0);

    dcache_ctrl ctrl0 (
        .clk, .rstn,
        .i_valid, .i_addr, .i_op, .i_size, .i_wdata, .i_wstrb, .i_signed,
        .o_done, .o_exc, .o_badv,
        .o_mem_rvalid, .i_mem_rready, .o_mem_raddr,
        .o_mem_wvalid, .i_mem_wready, .o_mem_waddr, .o_mem_wdata,
        .i_hit(hit), .i_victim_way(victim_way), .i_victim_tag(victim_tag),
        .i_victim_dirty(victim_dirty), .i_misaligned(misaligned),
        .i_rd_line0(rd_line0), .i_rd_line1(rd_line1),
        .o_req_addr(req_addr), .o_req_op(req_op), .o_req_size(req_size),
        .o_req_signed(req_signed), .o_req_wdata(req_wdata), .o_req_wstrb(req_wstrb),
        .o_rd_index(rd_index), .o_ram_we(ram_we), .o_fill_sel(fill_sel),
        .o_tag_we(tag_we), .o_dirty_set(dirty_set), .o_dirty_clr(dirty_clr),
        .o_lru_we(lru_we), .o_lru_way(lru_way), .o_sel_way(sel_way)
    );

    tag_store tags0 (
        .clk, .rstn,
        .i_rd_index(rd_index), .i_req_addr(req_addr), .i_tag_we(tag_we),
        .i_dirty_set(dirty_set), .i_dirty_clr(dirty_clr),
        .i_lru_we(lru_we), .i_lru_way(lru_way),
        .o_hit(hit), .o_victim_way(victim_way),
        .o_victim_tag(victim_tag), .o_victim_dirty(victim_dirty)
    );

    line_ram way0_ram (
        .clk, .i_raddr(rd_index), .i_waddr(req_addr.f.index), .i_wdata(wline),
        .i_we(wstrb_line & {LINE_BYTES{ram_we[0]}}), .o_rdata(rd_line0)
    );

    line_ram way1_ram (
        .clk, .i_raddr(rd_index), .i_waddr(req_addr.f.index), .i_wdata(wline),
        .i_we(wstrb_line & {LINE_BYTES{ram_we[1]}}), .o_rdata(rd_line1)
    );

    load_store_align align0 (
        .i_req_addr(req_addr), .i_size(req_size), .i_signed(req_signed),
        .i_wdata(req_wdata), .i_wstrb(req_wstrb),
        .i_line(sel_line), .i_fill_sel(fill_sel),
        .o_wline(wline), .o_wstrb_line(wstrb_line),
        .o_rdata(o_rdata), .o_misaligned(misaligned)
    );

endmodule

`default_nettype wire

// File: sim/tb_dcache_model.svh
`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

logic [7:0] arch_mem [logic [31:0]];   // architectural bytes written by stores
line_t      back_mem [logic [31:0]];   // written-back lines by line address

// cache state as two-way LRU predicts it
logic m_valid [`DCACHE_WAYS][NUM_SETS];
logic m_dirty [`DCACHE_WAYS][NUM_SETS];
tag_t m_tag   [`DCACHE_WAYS][NUM_SETS];
logic m_lru   [NUM_SETS];   // way replaced next

// untouched memory hashed from the whole address
function automatic logic [7:0] fill_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24] ^ h[15:8];
endfunction

function automatic logic [7:0] arch_byte(input logic [31:0] a);
    return arch_mem.exists(a) ? arch_mem[a] : fill_byte(a);
endfunction

function automatic line_t arch_line(input logic [31:0] base);
    line_t l;
    for (int b = 0; b < LINE_BYTES; b++) begin
        l[b*8 +: 8] = arch_byte(base + 32'(b));
    end
    return l;
endfunction

function automatic line_t back_line(input logic [31:0] base);
    line_t l;
    if (back_mem.exists(base)) begin
        return back_mem[base];
    end
    for (int b = 0; b < LINE_BYTES; b++) begin
        l[b*8 +: 8] = fill_byte(base + 32'(b));
    end
    return l;
endfunction

function automatic logic misaligned(input logic [31:0] a, input acc_size_e size);
    return (size == SIZE_HALF && a[0]) || (size == SIZE_WORD && a[1:0] != 2'b00);
endfunction

// little endian with extension from the top loaded bit
function automatic logic [31:0] load_value(input logic [31:0] a, input acc_size_e size,
                                           input logic sgn);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = arch_byte(a);
    b1 = arch_byte(a + 32'd1);
    case (size)
        SIZE_BYTE: return {{24{sgn & b0[7]}}, b0};
        SIZE_HALF: return {{16{sgn & b1[7]}}, b1, b0};
        default:   return {arch_byte(a + 32'd3), arch_byte(a + 32'd2), b1, b0};
    endcase
endfunction

task automatic apply_store(input logic [31:0] a, input logic [31:0] wdata,
                           input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
            arch_mem[{a[31:2], 2'b00} + 32'(i)] = wdata[i*8 +: 8];
        end
    end
endtask

task automatic model_reset();
    for (int s = 0; s < NUM_SETS; s++) begin
        m_lru[s] = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
            m_tag[w][s]   = '0;
        end
    end
endtask

// lookup, refill on a miss, then touch the way used
task automatic predict_access(input logic [31:0] a, input logic store, output logic hit,
                              output logic wb, output logic [31:0] wb_addr);
    index_t s;
    tag_t   t;
    logic   w;
    s       = a[BYTE_OFF_W +: INDEX_W];
    t       = a[31 -: TAG_W];
    w       = m_lru[s];
    hit     = 1'b0;
    for (int i = 0; i < `DCACHE_WAYS; i++) begin
        if (m_valid[i][s] && m_tag[i][s] == t) begin
            hit = 1'b1;
            w   = (i == 1);
        end
    end
    wb      = !hit && m_valid[w][s] && m_dirty[w][s];
    wb_addr = {m_tag[w][s], s, {BYTE_OFF_W{1'b0}}};
    if (!hit) begin
        m_valid[w][s] = 1'b1;
        m_tag[w][s]   = t;
        m_dirty[w][s] = 1'b0;
    end
    if (store) m_dirty[w][s] = 1'b1;
    m_lru[s] = ~w;
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_exc(input string name, input exc_code_t got, input exc_code_t exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
        fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
        fail_run($sformatf("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp));
    end
endtask

`endif

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache
    import dcache_addr_pkg::*;
    import dcache_access_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_REQ    = 3000;
    localparam int          MAX_WAIT   = 20;    // cycles allowed for one request
    localparam logic [31:0] SEED       = 32'hc660_f18b;
    localparam tag_t        TAG_POOL [4] = '{20'h00000, 20'h00001, 20'h5a5a5, 20'hfffff};

    logic                      clk;
    logic                      rstn;
    logic                      i_valid;
    logic [`DCACHE_ADDR_W-1:0] i_addr;
    logic                      i_op;
    logic [1:0]                i_size;
    logic [31:0]               i_wdata;
    logic [3:0]                i_wstrb;
    logic                      i_signed;
    logic                      o_done;
    logic [31:0]               o_rdata;
    exc_code_t                 o_exc;
    logic [`DCACHE_ADDR_W-1:0] o_badv;
    logic                      o_mem_rvalid;
    logic                      i_mem_rready;
    logic [`DCACHE_ADDR_W-1:0] o_mem_raddr;
    line_t                     i_mem_rdata;
    logic                      o_mem_wvalid;
    logic                      i_mem_wready;
    logic [`DCACHE_ADDR_W-1:0] o_mem_waddr;
    line_t                     o_mem_wdata;

    logic [31:0] stim_seed;
    logic [31:0] mem_seed;
    int          rd_wait;
    int          wr_wait;
    int          rd_count;
    int          wr_count;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    line_t       wr_data;

    `include "tb_dcache_model.svh"

    dcache_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    // memory responder with a 0 to 3 cycle ready delay
    always @(negedge clk) begin
        if (i_mem_rready) begin
            i_mem_rready = 1'b0;   // taken at the last rising edge
        end else if (o_mem_rvalid) begin
            if (rd_wait == 0) begin
                rd_count++;
                rd_addr      = o_mem_raddr;
                i_mem_rdata  = back_line(o_mem_raddr);
                i_mem_rready = 1'b1;
                mem_seed     = lcg_next(mem_seed);
                rd_wait      = int'(mem_seed[31:30]);
            end else begin
                rd_wait--;
            end
        end
        if (i_mem_wready) begin
            i_mem_wready = 1'b0;
        end else if (o_mem_wvalid) begin
            if (wr_wait == 0) begin
                wr_count++;
                wr_addr              = o_mem_waddr;
                wr_data              = o_mem_wdata;
                back_mem[o_mem_waddr] = o_mem_wdata;
                i_mem_wready         = 1'b1;
                mem_seed             = lcg_next(mem_seed);
                wr_wait              = int'(mem_seed[29:28]);
            end else begin
                wr_wait--;
            end
        end
    end

    initial begin
        #(NUM_REQ * MAX_WAIT * CLK_PERIOD);
        fail_run("watchdog expired before all requests finished");
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  lane_mask;
        logic [3:0]  strb;
        acc_size_e   size;
        logic        bad;
        logic        bubble;
        logic        exp_hit;
        logic        exp_wb;
        logic [31:0] exp_wb_addr;
        int          cycles;
        clk          = 1'b0;
        rstn         = 1'b0;
        i_valid      = 1'b0;
        i_addr       = '0;
        i_op         = OP_LOAD;
        i_size       = SIZE_BYTE;
        i_wdata      = '0;
        i_wstrb      = '0;
        i_signed     = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        i_mem_wready = 1'b0;
        stim_seed    = SEED;
        mem_seed     = SEED;
        rd_wait      = 0;
        wr_wait      = 0;
        bubble       = 1'b0;
        model_reset();
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        compare_flag("o_done", o_done, 1'b0);
        compare_flag("o_mem_rvalid", o_mem_rvalid, 1'b0);
        compare_flag("o_mem_wvalid", o_mem_wvalid, 1'b0);
        for (int n = 0; n < NUM_REQ; n++) begin
            r1    = next_rand();
            r2    = next_rand();
            wdata = next_rand();
            // four tags on two sets keep both ways busy
            addr  = {TAG_POOL[r1[31:30]], r1[29] ? index_t'(9) : index_t'(50),
                     {2{r1[28]}}, r1[27:26], r1[25] ? 2'b00 : r1[24:23]};
            size  = acc_size_e'(r1[22:21] == 2'd3 ? 2'd2 : r1[22:21]);
            case (size)
                SIZE_BYTE: lane_mask = 4'b0001 << addr[1:0];
                SIZE_HALF: lane_mask = addr[1] ? 4'b1100 : 4'b0011;
                default:   lane_mask = 4'b1111;
            endcase
            strb = lane_mask & (r2[29] ? 4'hf : r2[28:25]);
            if (r2[24] && r2[23]) begin
                i_valid = 1'b0;   // idle cycle between requests
                @(negedge clk);
                bubble = 1'b0;
            end
            i_valid  = 1'b1;
            i_addr   = addr;
            i_op     = r2[31];
            i_size   = size;
            i_wdata  = wdata;
            i_wstrb  = strb;
            i_signed = r2[30];
            rd_count = 0;
            wr_count = 0;
            cycles   = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > MAX_WAIT) begin
                    fail_run($sformatf("request %0d got no o_done within %0d cycles",
                                       n, MAX_WAIT));
                end
            end while (!o_done);
            i_valid = 1'b0;
            bad = misaligned(addr, size);
            compare_exc("o_exc", o_exc, bad ? EXC_ALE : EXC_NONE);
            if (bad) begin
                compare_word("o_badv", o_badv, addr);
                compare_count("o_done latency", cycles, bubble ? 2 : 1);
                compare_count("memory reads", rd_count, 0);
                compare_count("memory writes", wr_count, 0);
                bubble = 1'b0;
            end else begin
                predict_access(addr, i_op, exp_hit, exp_wb, exp_wb_addr);
                if (i_op == OP_LOAD) begin
                    compare_word("o_rdata", o_rdata, load_value(addr, size, i_signed));
                end
                if (exp_hit) begin
                    compare_count("o_done latency", cycles, bubble ? 2 : 1);
                    compare_count("memory reads", rd_count, 0);
                    compare_count("memory writes", wr_count, 0);
                end else begin
                    compare_count("memory reads", rd_count, 1);
                    compare_word("o_mem_raddr", rd_addr, {addr[31:BYTE_OFF_W], 6'b0});
                    compare_count("memory writes", wr_count, exp_wb ? 1 : 0);
                    if (exp_wb) begin
                        compare_word("o_mem_waddr", wr_addr, exp_wb_addr);
                        compare_line("o_mem_wdata", wr_data, arch_line(exp_wb_addr));
                    end
                end
                if (i_op == OP_STORE) apply_store(addr, wdata, strb);
                bubble = exp_hit && (i_op == OP_STORE);   // store hit idles one cycle
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+sim
hw/dcache_addr_pkg.sv
hw/dcache_access_pkg.sv
hw/line_ram.sv
hw/tag_store.sv
hw/load_store_align.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# compile the dcache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f build.f -o tb_dcache \
    && ./obj_dir/tb_dcache \
    || { echo "simulation run failed"; exit 1; }
